// ==== hdl/edDecodePkg.sv ====
// ED prefix decoder definitions
`default_nettype none

package edDecodePkg;

  // ------------------------------
  // Basic field types
  // ------------------------------
  typedef logic [7:0] opcodeT;   // Byte after the ED prefix
  typedef logic [6:0] mCycleT;   // One-hot, bit 0 is M1
  typedef logic [3:0] busSelT;   // Register code for bus A / bus B
  typedef logic [3:0] aluOpT;
  typedef logic [3:0] incDecT;   // Bit 3 decrement, bits 1:0 pair
  typedef logic [2:0] specialLdT;

  typedef enum logic [2:0] {
    aBC   = 3'd0,
    aDE   = 3'd1,
    aXY   = 3'd2,
    aIOA  = 3'd4,
    aSP   = 3'd5,
    aZI   = 3'd6,
    aNone = 3'd7
  } addrSelT;

  // Bus register codes
  localparam busSelT selH     = 4'd4;
  localparam busSelT selL     = 4'd5;
  localparam busSelT selDi    = 4'd6;   // Data input latch
  localparam busSelT selAcc   = 4'd7;
  localparam busSelT selSpLo  = 4'd8;
  localparam busSelT selSpHi  = 4'd9;
  localparam busSelT selConst = 4'd10;  // 0 on bus A, 1 on bus B
  localparam busSelT selZero  = 4'd14;  // 0 on bus B

  // ALU operations
  localparam aluOpT aluAdd = 4'd0;
  localparam aluOpT aluAdc = 4'd1;
  localparam aluOpT aluSub = 4'd2;
  localparam aluOpT aluSbc = 4'd3;
  localparam aluOpT aluCp  = 4'd7;
  localparam aluOpT aluRld = 4'd13;
  localparam aluOpT aluRrd = 4'd14;

  // ------------------------------
  // Microcode word
  // ------------------------------
  typedef struct packed {
    logic [2:0] mCycles;
    logic [2:0] tStates;
    logic       incPc;
    logic       incWz;
    incDecT     incDec16;
    logic       readToReg;
    logic       readToAcc;
    busSelT     busA;
    busSelT     busB;
    aluOpT      aluOp;
    logic       saveAlu;
    logic       preserveC;
    addrSelT    addrSel;
    logic       iorq;
    logic       jump;
    logic       ldZ;
    logic       ldW;
    specialLdT  specialLd;
    logic       iRetn;
    logic       iBt;
    logic       iBc;
    logic       iBtr;
    logic       iRld;
    logic       iRrd;
    logic       iInrc;
    logic [1:0] iMode;        // 3 leaves the mode alone
    logic       noRead;
    logic       write;
  } microT;

  typedef struct packed {
    logic  hit;
    microT micro;
  } groupOutT;

  // Idle word, every group decoder starts from this
  function automatic microT defaultMicro(input opcodeT opcode, input mCycleT mCycle);
    microT m;
    m = '0;
    m.mCycles = 3'd1;
    m.tStates = mCycle[0] ? 3'd4 : 3'd3;  // Opcode fetch is one T state longer
    m.aluOp   = {1'b0, opcode[5:3]};
    m.addrSel = aNone;
    m.iMode   = 2'd3;
    return m;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/blockDecode.sv ====
// Block transfer and block I/O decode
`timescale 1ns/1ns
`default_nettype none

module blockDecode (
  input  edDecodePkg::opcodeT   opcode,
  input  edDecodePkg::mCycleT   mCycle,
  output edDecodePkg::groupOutT result
);

  logic dirDown;  // Opcode bit 3, step HL/DE downwards

  assign dirDown = opcode[3];

  always_comb
  begin
    result.hit   = (opcode[7:5] == 3'b101) && !opcode[2];  // 101xx0yy
    result.micro = edDecodePkg::defaultMicro(opcode, mCycle);
    if (result.hit)
    begin
      result.micro.mCycles = 3'd4;
      case (1'b1)
        mCycle[0]:
        begin
          if (opcode[1])
          begin
            // INI/OUTI family, B - 1 into B
            result.micro.tStates   = opcode[0] ? 3'd5 : 3'd4;
            result.micro.addrSel   = opcode[0] ? edDecodePkg::aXY : edDecodePkg::aBC;
            result.micro.busB      = edDecodePkg::selConst;
            result.micro.busA      = 4'd0;
            result.micro.readToReg = 1'b1;
            result.micro.saveAlu   = 1'b1;
            result.micro.aluOp     = edDecodePkg::aluSub;
          end
          else
          begin
            result.micro.addrSel  = edDecodePkg::aXY;
            result.micro.incDec16 = 4'b1100;  // BC - 1
          end
        end
        mCycle[1]:
        begin
          result.micro.busB = edDecodePkg::selDi;
          case (opcode[1:0])
            2'b00:
            begin
              result.micro.busA     = edDecodePkg::selAcc;
              result.micro.aluOp    = edDecodePkg::aluAdd;
              result.micro.addrSel  = edDecodePkg::aDE;
              result.micro.incDec16 = {dirDown, 3'b110};
            end
            2'b01:
            begin
              result.micro.busA      = edDecodePkg::selAcc;
              result.micro.aluOp     = edDecodePkg::aluCp;
              result.micro.saveAlu   = 1'b1;
              result.micro.preserveC = 1'b1;  // Compare leaves carry alone
              result.micro.incDec16  = {dirDown, 3'b110};
            end
            2'b10:
            begin
              result.micro.iorq    = 1'b1;    // Port read
              result.micro.addrSel = edDecodePkg::aXY;
            end
            default:
            begin
              result.micro.addrSel  = edDecodePkg::aBC;
              result.micro.incDec16 = {dirDown, 3'b110};
            end
          endcase
        end
        mCycle[2]:
        begin
          case (opcode[1:0])
            2'b00:
            begin
              result.micro.iBt      = 1'b1;
              result.micro.write    = 1'b1;
              result.micro.tStates  = 3'd5;
              result.micro.incDec16 = {dirDown, 3'b101};  // DE step
            end
            2'b01:
            begin
              result.micro.iBc     = 1'b1;
              result.micro.noRead  = 1'b1;
              result.micro.tStates = 3'd5;
            end
            2'b10:
            begin
              result.micro.iBtr     = 1'b1;
              result.micro.write    = 1'b1;
              result.micro.tStates  = 3'd4;
              result.micro.incDec16 = {dirDown, 3'b110};
            end
            default:
            begin
              result.micro.iBtr     = 1'b1;
              result.micro.write    = 1'b1;
              result.micro.iorq     = 1'b1;  // Port write
              result.micro.incDec16 = {dirDown, 3'b010};
            end
          endcase
        end
        mCycle[3]:
        begin
          // Repeat check cycle
          result.micro.noRead  = 1'b1;
          result.micro.tStates = 3'd5;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wordDecode.sv ====
// 16-bit memory loads and HL arithmetic
`timescale 1ns/1ns
`default_nettype none

module wordDecode (
  input  edDecodePkg::opcodeT   opcode,
  input  edDecodePkg::mCycleT   mCycle,
  output edDecodePkg::groupOutT result
);

  logic isLoad;   // LD dd,(nn) / LD (nn),dd
  logic toReg;    // Memory into register pair
  logic [1:0] pair;

  // Register code of one byte of a pair, SP is special
  function automatic edDecodePkg::busSelT pairCode(input logic [1:0] sel, input logic highByte);
    if (sel == 2'b11)
      return highByte ? edDecodePkg::selSpHi : edDecodePkg::selSpLo;
    return {1'b0, sel, ~highByte};
  endfunction

  assign isLoad = opcode[0];
  assign toReg  = opcode[3];
  assign pair   = opcode[5:4];

  always_comb
  begin
    result.hit   = (opcode[7:6] == 2'b01) && (opcode[2:1] == 2'b01);
    result.micro = edDecodePkg::defaultMicro(opcode, mCycle);
    if (result.hit && isLoad)
    begin
      result.micro.mCycles = 3'd5;
      case (1'b1)
        mCycle[1]:
        begin
          result.micro.incPc = 1'b1;
          result.micro.ldZ   = 1'b1;
        end
        mCycle[2]:
        begin
          result.micro.addrSel = edDecodePkg::aZI;
          result.micro.incPc   = 1'b1;
          result.micro.ldW     = 1'b1;
          if (!toReg)
            result.micro.busB = pairCode(pair, 1'b0);  // Low byte out first
        end
        mCycle[3]:
        begin
          result.micro.incWz   = 1'b1;
          result.micro.addrSel = edDecodePkg::aZI;
          if (toReg)
          begin
            result.micro.readToReg = 1'b1;
            result.micro.busA      = pairCode(pair, 1'b0);
          end
          else
          begin
            result.micro.write = 1'b1;
            result.micro.busB  = pairCode(pair, 1'b1);
          end
        end
        mCycle[4]:
        begin
          if (toReg)
          begin
            result.micro.readToReg = 1'b1;
            result.micro.busA      = pairCode(pair, 1'b1);
          end
          else
            result.micro.write = 1'b1;
        end
        default:
        begin
        end
      endcase
    end
    else if (result.hit)
    begin
      // ADC HL,ss when bit 3 set, SBC HL,ss otherwise
      result.micro.mCycles = 3'd3;
      if (mCycle[1] || mCycle[2])
      begin
        result.micro.noRead    = 1'b1;
        result.micro.readToReg = 1'b1;
        result.micro.saveAlu   = 1'b1;
        result.micro.aluOp     = opcode[3] ? edDecodePkg::aluAdc : edDecodePkg::aluSbc;
        result.micro.busA      = mCycle[1] ? edDecodePkg::selL : edDecodePkg::selH;
        result.micro.busB      = pairCode(pair, mCycle[2]);
      end
      if (mCycle[1])
        result.micro.tStates = 3'd4;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ioDecode.sv ====
// IN r,(C) and OUT (C),r decode
`timescale 1ns/1ns
`default_nettype none

module ioDecode (
  input  edDecodePkg::opcodeT   opcode,
  input  edDecodePkg::mCycleT   mCycle,
  output edDecodePkg::groupOutT result
);

  logic [2:0] r;
  logic isOut;
  logic rIsFlags;  // r == 6 means flags only, or zero out

  assign r        = opcode[5:3];
  assign isOut    = opcode[0];
  assign rIsFlags = (r == 3'b110);

  always_comb
  begin
    result.hit   = (opcode[7:6] == 2'b01) && (opcode[2:1] == 2'b00);
    result.micro = edDecodePkg::defaultMicro(opcode, mCycle);
    if (result.hit)
    begin
      result.micro.mCycles = 3'd2;
      if (mCycle[0])
      begin
        result.micro.addrSel = edDecodePkg::aBC;  // Port address from BC
        if (isOut)
          result.micro.busB = rIsFlags ? edDecodePkg::selZero : {1'b0, r};
      end
      if (mCycle[1])
      begin
        result.micro.iorq = 1'b1;
        if (isOut)
          result.micro.write = 1'b1;
        else
        begin
          result.micro.iInrc = 1'b1;  // Flags from the port value
          if (!rIsFlags)
          begin
            result.micro.readToReg = 1'b1;
            result.micro.busA      = {1'b0, r};
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/miscDecode.sv ====
// Special loads, NEG, IM, RLD/RRD and RETI/RETN
`timescale 1ns/1ns
`default_nettype none

module miscDecode (
  input  edDecodePkg::opcodeT   opcode,
  input  edDecodePkg::mCycleT   mCycle,
  output edDecodePkg::groupOutT result
);

  logic isRld;

  assign isRld = opcode[3];  // 6F is RLD, 67 is RRD

  always_comb
  begin
    result.hit   = 1'b1;
    result.micro = edDecodePkg::defaultMicro(opcode, mCycle);
    casez (opcode)
      // ------------------------------
      // LD A,I / A,R / I,A / R,A
      // ------------------------------
      8'b010??111:
      begin
        result.micro.specialLd = {1'b1, ~opcode[4], opcode[3]};
        result.micro.tStates   = 3'd5;
      end
      8'b01???100:
      begin
        // NEG as 0 - A
        result.micro.aluOp     = edDecodePkg::aluSub;
        result.micro.busA      = edDecodePkg::selConst;
        result.micro.busB      = edDecodePkg::selAcc;
        result.micro.readToAcc = 1'b1;
        result.micro.saveAlu   = 1'b1;
      end
      8'b01000110, 8'b01001110, 8'b01100110, 8'b01101110:
        result.micro.iMode = 2'd0;
      8'b01010110, 8'b01110110:
        result.micro.iMode = 2'd1;
      8'b01011110, 8'b01110111:
        result.micro.iMode = 2'd2;
      // ------------------------------
      // Nibble rotates through (HL)
      // ------------------------------
      8'b0110?111:
      begin
        result.micro.mCycles = 3'd4;
        case (1'b1)
          mCycle[1]:
          begin
            result.micro.noRead  = 1'b1;
            result.micro.addrSel = edDecodePkg::aXY;
          end
          mCycle[2]:
          begin
            result.micro.readToReg = 1'b1;
            result.micro.busB      = edDecodePkg::selDi;
            result.micro.busA      = edDecodePkg::selAcc;
            result.micro.aluOp     = isRld ? edDecodePkg::aluRld : edDecodePkg::aluRrd;
            result.micro.tStates   = 3'd4;
            result.micro.addrSel   = edDecodePkg::aXY;
            result.micro.saveAlu   = 1'b1;
          end
          mCycle[3]:
          begin
            result.micro.write = 1'b1;  // Rotated byte back to (HL)
            result.micro.iRld  = isRld;
            result.micro.iRrd  = !isRld;
          end
          default:
          begin
          end
        endcase
      end
      8'b01???101:
      begin
        // RETI/RETN pop PC through WZ
        result.micro.mCycles = 3'd3;
        case (1'b1)
          mCycle[0]:
            result.micro.addrSel = edDecodePkg::aSP;
          mCycle[1]:
          begin
            result.micro.incDec16 = 4'b0111;  // SP + 1
            result.micro.addrSel  = edDecodePkg::aSP;
            result.micro.ldZ      = 1'b1;
          end
          mCycle[2]:
          begin
            result.micro.jump     = 1'b1;
            result.micro.incDec16 = 4'b0111;
            result.micro.iRetn    = 1'b1;   // Restore IFF1 from IFF2
          end
          default:
          begin
          end
        endcase
      end
      default:
        result.hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/edDecoder.sv ====
// ED prefix microcode decoder
`timescale 1ns/1ns
`default_nettype none

module edDecoder (
  input  edDecodePkg::opcodeT opcode,
  input  edDecodePkg::mCycleT mCycle,
  output edDecodePkg::microT  micro
);

  edDecodePkg::groupOutT [3:0] groupOut;  // One per instruction group

  // ------------------------------
  // Group decoders
  // ------------------------------
  blockDecode uBlock (
    .opcode (opcode),
    .mCycle (mCycle),
    .result (groupOut[0])
  );

  wordDecode uWord (
    .opcode (opcode),
    .mCycle (mCycle),
    .result (groupOut[1])
  );

  ioDecode uIo (
    .opcode (opcode),
    .mCycle (mCycle),
    .result (groupOut[2])
  );

  miscDecode uMisc (
    .opcode (opcode),
    .mCycle (mCycle),
    .result (groupOut[3])
  );

  // Groups are disjoint, at most one hit
  always_comb
  begin
    micro = edDecodePkg::defaultMicro(opcode, mCycle);
    for (int i = 0; i < 4; i++)
    begin
      if (groupOut[i].hit)
        micro = groupOut[i].micro;
    end
  end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module clockGen (
  output logic clk,
  output logic arstN
);

  localparam int halfPeriodNs = 50;  // 100 ns period
  localparam int resetCycles  = 16;

  initial
  begin
    clk = 1'b0;
    forever #(halfPeriodNs) clk = ~clk;
  end

  initial
  begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/edDecoder_properties.sv ====
// Decoder output properties
`timescale 1ns/1ns
`default_nettype none

module edDecoderProperties (
  input logic                clk,
  input edDecodePkg::opcodeT opcode,
  input edDecodePkg::mCycleT mCycle,
  input edDecodePkg::microT  micro
);

  int                 failCount = 0;
  logic               isIm;
  logic               known;   // Opcode belongs to one of the decoded groups
  edDecodePkg::microT idle;    // Word for an opcode that no group decodes

  assign isIm  = opcode inside {8'h46, 8'h4E, 8'h66, 8'h6E, 8'h56, 8'h76, 8'h5E, 8'h77};
  assign known = ((opcode[7:5] == 3'b101) && !opcode[2]) ||
                 ((opcode[7:6] == 2'b01) && !(opcode inside {8'h7E, 8'h7F}));

  always_comb
  begin
    idle         = '0;
    idle.mCycles = 3'd1;
    idle.tStates = mCycle[0] ? 3'd4 : 3'd3;  // M1 has four T states
    idle.aluOp   = {1'b0, opcode[5:3]};
    idle.addrSel = edDecodePkg::aNone;
    idle.iMode   = 2'd3;
  end

  // ------------------------------
  // Output rules
  // ------------------------------
  idleWord: assert property (@(negedge clk)
    !known |-> (micro == idle))
  else
  begin
    failCount++;
    $error("unmatched opcode %h does not give the idle word", opcode);
  end

  writeNoRead: assert property (@(negedge clk) !(micro.write && micro.noRead))
  else
  begin
    failCount++;
    $error("write and noRead both set for opcode %h", opcode);
  end

  modeOnlyForIm: assert property (@(negedge clk) ((micro.iMode != 2'd3) == isIm))
  else
  begin
    failCount++;
    $error("iMode %0d does not match opcode %h", micro.iMode, opcode);
  end

endmodule

`default_nettype wire

// ==== verification/edDecoderTb.sv ====
// ED decoder testbench
`timescale 1ns/1ns
`default_nettype none

module edDecoderTb;

  localparam int stimCycles = 16 + 256 * 7 + 500;
  localparam int watchdogNs = stimCycles * 100 * 3 / 2;

  logic                clk;
  logic                arstN;
  edDecodePkg::opcodeT opcode;
  edDecodePkg::mCycleT mCycle;
  edDecodePkg::microT  micro;

  logic               active;     // Compare enable
  logic [31:0]        rng;
  edDecodePkg::microT expWord;
  edDecodePkg::microT careWord;   // Fields the rules define
  edDecodePkg::microT wordMask;
  string              ctx;
  int                 checks      = 0;
  int                 wordErrors  = 0;
  int                 addrErrors  = 0;
  int                 busErrors   = 0;
  int                 totalErrors = 0;

  clockGen uClock (
    .clk   (clk),
    .arstN (arstN)
  );

  edDecoder dut (
    .opcode (opcode),
    .mCycle (mCycle),
    .micro  (micro)
  );

  bind edDecoder edDecoderProperties props (
    .clk    (edDecoderTb.clk),
    .opcode (opcode),
    .mCycle (mCycle),
    .micro  (micro)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic edDecodePkg::microT expectedMicro(input edDecodePkg::opcodeT op,
      input edDecodePkg::mCycleT cyc, output edDecodePkg::microT care);
    edDecodePkg::microT  e;
    edDecodePkg::busSelT lo;
    edDecodePkg::busSelT hi;
    logic [1:0]          yy;
    logic [2:0]          r;
    int                  n;       // Cycle number, 1 is M1
    n = 0;
    for (int k = 0; k < 7; k++)
      if (cyc[k])
        n = k + 1;
    e = '0;
    e.mCycles = 3'd1;
    e.tStates = (n == 1) ? 3'd4 : 3'd3;
    e.aluOp   = {1'b0, op[5:3]};
    e.addrSel = edDecodePkg::aNone;
    e.iMode   = 2'd3;
    care = '1;
    yy = op[1:0];
    r  = op[5:3];
    hi = edDecodePkg::busSelT'(2 * int'(op[5:4]));  // B, D, H
    lo = hi + 4'd1;
    if (op[5:4] == 2'b11)
    begin
      lo = 4'd8;
      hi = 4'd9;
    end
    if ((op[7:5] == 3'b101) && !op[2])
    begin
      // Block group, only the documented fields
      care = '0;
      care.mCycles = '1;
      care.iBt     = 1'b1;
      care.iBc     = 1'b1;
      care.iBtr    = 1'b1;
      care.write   = 1'b1;
      care.noRead  = 1'b1;
      e.mCycles = 3'd4;
      e.iBt     = (n == 3) && (yy == 2'd0);
      e.iBc     = (n == 3) && (yy == 2'd1);
      e.iBtr    = (n == 3) && yy[1];
      e.write   = (n == 3) && (yy != 2'd1);
      e.noRead  = (n == 4) || ((n == 3) && (yy == 2'd1));
      if (n == 4)
      begin
        care.tStates = '1;
        e.tStates    = 3'd5;
      end
      if (((n == 2) && (yy != 2'd2)) || ((n == 3) && (yy == 2'd2)))
      begin
        care.incDec16[3] = 1'b1;   // HL step after the port read for INI
        e.incDec16[3]    = op[3];
      end
      if ((n == 2) && (yy == 2'd1))
      begin
        care.aluOp     = '1;
        care.preserveC = 1'b1;
        e.aluOp        = 4'd7;
        e.preserveC    = 1'b1;
      end
      if ((n == 2) || (n == 3))
      begin
        care.iorq = 1'b1;
        e.iorq    = ((n == 2) && (yy == 2'd2)) || ((n == 3) && (yy == 2'd3));
      end
    end
    else if (op[7:6] == 2'b01)
    begin
      case (op[2:0])
        3'b000, 3'b001:
        begin
          e.mCycles = 3'd2;
          if (n == 1)
          begin
            e.addrSel = edDecodePkg::aBC;
            if (op[0])
              e.busB = (r == 3'd6) ? 4'd14 : {1'b0, r};
          end
          if (n == 2)
          begin
            e.iorq = 1'b1;
            if (op[0])
              e.write = 1'b1;
            else
            begin
              e.iInrc = 1'b1;
              if (r != 3'd6)
              begin
                e.readToReg = 1'b1;
                e.busA      = {1'b0, r};
              end
            end
          end
        end
        3'b010:
        begin
          // ADC HL,ss / SBC HL,ss
          care = '0;
          care.mCycles = '1;
          e.mCycles = 3'd3;
          if ((n == 2) || (n == 3))
          begin
            care.noRead    = 1'b1;
            care.readToReg = 1'b1;
            care.saveAlu   = 1'b1;
            care.write     = 1'b1;
            care.aluOp     = '1;
            care.busA      = '1;
            care.busB      = '1;
            e.noRead       = 1'b1;
            e.readToReg    = 1'b1;
            e.saveAlu      = 1'b1;
            e.aluOp        = op[3] ? 4'd1 : 4'd3;
            e.busA         = (n == 2) ? 4'd5 : 4'd4;
            e.busB         = (n == 2) ? lo : hi;
          end
        end
        3'b011:
        begin
          care = '0;
          care.mCycles   = '1;
          care.incPc     = 1'b1;
          care.ldZ       = 1'b1;
          care.ldW       = 1'b1;
          care.write     = 1'b1;
          care.readToReg = 1'b1;
          e.mCycles = 3'd5;
          e.incPc   = (n == 2) || (n == 3);
          e.ldZ     = (n == 2);
          e.ldW     = (n == 3);
          if (op[3])
          begin
            e.readToReg = (n == 4) || (n == 5);
            if ((n == 4) || (n == 5))
            begin
              care.busA = '1;
              e.busA    = (n == 4) ? lo : hi;
            end
          end
          else
          begin
            e.write = (n == 4) || (n == 5);
            if ((n == 3) || (n == 4))
            begin
              care.busB = '1;
              e.busB    = (n == 3) ? lo : hi;
            end
          end
        end
        3'b100:
        begin
          e.aluOp     = 4'd2;   // 0 - A
          e.busA      = 4'd10;
          e.busB      = 4'd7;
          e.readToAcc = 1'b1;
          e.saveAlu   = 1'b1;
        end
        3'b101:
        begin
          care = '0;
          care.mCycles = '1;
          care.jump    = 1'b1;
          care.iRetn   = 1'b1;
          care.write   = 1'b1;
          e.mCycles = 3'd3;
          e.jump    = (n == 3);
          e.iRetn   = (n == 3);
          if (n <= 2)
          begin
            care.addrSel = edDecodePkg::addrSelT'(3'b111);
            e.addrSel    = edDecodePkg::aSP;
          end
        end
        3'b110:
        begin
          if (op != 8'h7E)
            e.iMode = (op[4:3] == 2'b11) ? 2'd2 : ((op[4:3] == 2'b10) ? 2'd1 : 2'd0);
        end
        default:
        begin
          if (!op[5])
          begin
            e.tStates = 3'd5;
            case (op[4:3])
              2'b00:   e.specialLd = 3'd6;   // I from A
              2'b01:   e.specialLd = 3'd7;
              2'b10:   e.specialLd = 3'd4;
              default: e.specialLd = 3'd5;
            endcase
          end
          else if (op == 8'h77)
            e.iMode = 2'd2;
          else if (!op[4])
          begin
            // RLD 6F, RRD 67
            care = '0;
            care.mCycles = '1;
            care.write   = 1'b1;
            care.iRld    = 1'b1;
            care.iRrd    = 1'b1;
            e.mCycles = 3'd4;
            e.write   = (n == 4);
            e.iRld    = (n == 4) && op[3];
            e.iRrd    = (n == 4) && !op[3];
            if (n == 3)
            begin
              care.aluOp = '1;
              e.aluOp    = op[3] ? 4'd13 : 4'd14;
            end
          end
        end
      endcase
    end
    return e;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic checkMicro(input edDecodePkg::microT actual, input edDecodePkg::microT expected,
      input edDecodePkg::microT care, input string where);
    if (((actual ^ expected) & care) !== '0)
    begin
      wordErrors++;
      $display("Fail %0t ns: %s word %h, expected %h, mask %h", $time, where, actual,
               expected, care);
    end
  endtask

  task automatic checkAddr(input edDecodePkg::addrSelT actual,
      input edDecodePkg::addrSelT expected, input string where);
    if (actual !== expected)
    begin
      addrErrors++;
      $display("Fail %0t ns: %s addrSel %0d, expected %0d", $time, where, actual, expected);
    end
  endtask

  task automatic checkBus(input edDecodePkg::busSelT actual, input edDecodePkg::busSelT expected,
      input string busName, input string where);
    if (actual !== expected)
    begin
      busErrors++;
      $display("Fail %0t ns: %s %s %0d, expected %0d", $time, where, busName, actual, expected);
    end
  endtask

  // Outputs settle long before the falling edge
  always @(negedge clk)
  begin
    if (active)
    begin
      expWord = expectedMicro(opcode, mCycle, careWord);
      ctx = $sformatf("opcode %h cycle %b", opcode, mCycle);
      checks++;
      wordMask = careWord;
      wordMask.addrSel = edDecodePkg::addrSelT'(3'b000);
      wordMask.busA = '0;
      wordMask.busB = '0;
      checkMicro(micro, expWord, wordMask, ctx);
      if (3'(careWord.addrSel) != 3'd0)
        checkAddr(micro.addrSel, expWord.addrSel, ctx);
      if (careWord.busA != 4'd0)
        checkBus(micro.busA, expWord.busA, "busA", ctx);
      if (careWord.busB != 4'd0)
        checkBus(micro.busB, expWord.busB, "busB", ctx);
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial
  begin
    opcode = '0;
    mCycle = 7'b0000001;
    active = 1'b0;
    rng    = 32'd28;
    wait (arstN === 1'b1);
    for (int op = 0; op < 256; op++)
    begin
      for (int c = 0; c < 7; c++)
      begin
        @(posedge clk);
        opcode <= edDecodePkg::opcodeT'(op);
        mCycle <= edDecodePkg::mCycleT'(1 << c);
        active <= 1'b1;
      end
    end
    repeat (500)
    begin
      @(posedge clk);
      rng = xorshift32(rng);
      opcode <= rng[7:0];
      mCycle <= edDecodePkg::mCycleT'(1 << (int'(rng[15:8]) % 7));
    end
    @(posedge clk);
    active <= 1'b0;
    @(negedge clk);
    totalErrors = wordErrors + addrErrors + busErrors + dut.props.failCount;
    $display("Checks %0d, word errors %0d, address errors %0d, bus errors %0d, assertion failures %0d",
             checks, wordErrors, addrErrors, busErrors, dut.props.failCount);
    if (totalErrors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(watchdogNs);
    $display("Timeout: stimulus did not finish within %0d ns", watchdogNs);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== edDecoder.f ====
hdl/edDecodePkg.sv
hdl/blockDecode.sv
hdl/wordDecode.sv
hdl/ioDecode.sv
hdl/miscDecode.sv
hdl/edDecoder.sv
verification/clockGen.sv
verification/edDecoder_properties.sv
verification/edDecoderTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ED decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module edDecoderTb \
  -f edDecoder.f --Mdir obj_dir -o edDecoderSim

./obj_dir/edDecoderSim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
